/* compile.f */
source/aes_pkg.sv
source/aes_key_schedule.sv
source/aes_cipher.sv
source/aes_wb_regs.sv
source/aes_top.sv
tests/aes_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the AES testbench with Verilator; exit status is the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module aes_tb -f compile.f -o aes_sim \
	&& ./obj_dir/aes_sim \
	|| { echo "simulation did not pass"; exit 1; }

/* source/aes_cipher.sv */
`timescale 1ns/100ps

module aes_cipher import aes_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  aes_block_t plaintext,
	input  aes_key_t   round_key,
	input  round_no_t  round_no,
	output logic       load,
	output logic       advance,
	output aes_block_t ciphertext,
	output logic       busy,
	output logic       done
);

	aes_block_t state_q;
	logic       busy_q;
	logic       done_q;

	aes_block_t subbed;
	aes_block_t shifted;
	aes_block_t mixed;
	aes_block_t round_out;
	logic       last_round;

	function automatic logic [31:0] mix_column(input logic [31:0] col);
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		return {gm2(a0) ^ gm3(a1) ^ a2 ^ a3,
		        a0 ^ gm2(a1) ^ gm3(a2) ^ a3,
		        a0 ^ a1 ^ gm2(a2) ^ gm3(a3),
		        gm3(a0) ^ a1 ^ a2 ^ gm2(a3)};
	endfunction

	assign last_round = (round_no == num_rounds);

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			subbed.b[i] = sbox(state_q.b[i]);
		end
		// Row r of column c comes from column c + r.
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted.b[4*c + r] = subbed.b[4*((c + r) % 4) + r];
			end
		end
		for (int c = 0; c < 4; c++) begin
			mixed.w[c] = mix_column(shifted.w[c]);
		end
		round_out = (last_round ? shifted : mixed) ^ round_key;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (start) begin
				busy_q <= 1'b1;
			end else if (busy_q && last_round) begin
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	// Initial AddRoundKey on start, then one round per cycle.
	always_ff @(posedge clk) begin
		if (start) begin
			state_q <= plaintext ^ round_key;
		end else if (busy_q) begin
			state_q <= round_out;
		end
	end

	assign load       = start;
	assign advance    = busy_q && !last_round;
	assign ciphertext = state_q;
	assign busy       = busy_q;
	assign done       = done_q;

	assert property (@(posedge clk) disable iff (reset) start |-> !busy_q);

	// Ten rounds lie between start and done, and the schedule rests on round 10.
	assert property (@(posedge clk) disable iff (reset)
		done_q |-> $past(start, 11) && round_no == num_rounds);

endmodule

/* source/aes_key_schedule.sv */
`timescale 1ns/100ps

module aes_key_schedule import aes_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  aes_key_t  key,
	input  logic      load,
	input  logic      advance,
	output aes_key_t  round_key,
	output round_no_t round_no
);

	aes_key_t  key_q;
	logic [7:0] rcon_q;
	round_no_t no_q;

	aes_key_t   cur_key;
	logic [7:0] cur_rcon;
	round_no_t  cur_no;
	logic [31:0] rot_word;
	logic [31:0] temp_word;
	aes_key_t   next_key;

	// Round key 0 passes straight through while load is high.
	always_comb begin
		cur_key  = load ? key : key_q;
		cur_rcon = load ? 8'h01 : rcon_q;
		cur_no   = load ? 4'd0 : no_q;
	end

	// RotWord, SubWord and round constant on the last word, then chained XOR.
	always_comb begin
		rot_word  = {cur_key[3][23:0], cur_key[3][31:24]};
		temp_word = {sbox(rot_word[31:24]), sbox(rot_word[23:16]),
		             sbox(rot_word[15:8]), sbox(rot_word[7:0])};
		temp_word = temp_word ^ {cur_rcon, 24'h000000};
		next_key[0] = cur_key[0] ^ temp_word;
		for (int i = 1; i < 4; i++) begin
			next_key[i] = cur_key[i] ^ next_key[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			no_q <= 4'd0;
		end else if (load || advance) begin
			no_q <= cur_no + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (load || advance) begin
			key_q  <= next_key;
			rcon_q <= gm2(cur_rcon);
		end
	end

	assign round_key = cur_key;
	assign round_no  = cur_no;

	// The cipher must stop stepping once the last round key is out.
	assert property (@(posedge clk) disable iff (reset)
		advance |-> round_no != num_rounds);

endmodule

/* source/aes_pkg.sv */
package aes_pkg;

	// AES state. Byte 0 is the most significant byte, column 0 the most significant word.
	typedef union packed {
		logic [0:15][7:0] b;
		logic [0:3][31:0] w;
	} aes_block_t;

	typedef logic [0:3][31:0] aes_key_t;

	typedef logic [3:0] round_no_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;
		logic [31:0] dat;
		logic [3:0]  sel;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	localparam round_no_t num_rounds = 4'd10;

	// Forward S-box, one row of 16 entries per literal.
	localparam logic [0:255][7:0] sbox_table = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic logic [7:0] sbox(input logic [7:0] b);
		return sbox_table[b];
	endfunction

	// Multiply by x, reduced by x^8 + x^4 + x^3 + x + 1.
	function automatic logic [7:0] gm2(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] gm3(input logic [7:0] b);
		return gm2(b) ^ b;
	endfunction

endpackage

/* source/aes_top.sv */
`timescale 1ns/100ps

module aes_top import aes_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  wb_req_t wb_in,
	output wb_rsp_t wb_out
);

	aes_key_t   key;
	aes_block_t plaintext;
	logic       start;
	aes_block_t ciphertext;
	logic       busy;
	logic       done;
	logic       load;
	logic       advance;
	aes_key_t   round_key;
	round_no_t  round_no;

	aes_wb_regs i_regs (
		.clk        (clk),
		.reset      (reset),
		.wb_in      (wb_in),
		.wb_out     (wb_out),
		.key        (key),
		.plaintext  (plaintext),
		.start      (start),
		.ciphertext (ciphertext),
		.busy       (busy),
		.done       (done)
	);

	// Round keys are produced one step ahead of the datapath.
	aes_key_schedule i_key_schedule (
		.clk       (clk),
		.reset     (reset),
		.key       (key),
		.load      (load),
		.advance   (advance),
		.round_key (round_key),
		.round_no  (round_no)
	);

	aes_cipher i_cipher (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.plaintext  (plaintext),
		.round_key  (round_key),
		.round_no   (round_no),
		.load       (load),
		.advance    (advance),
		.ciphertext (ciphertext),
		.busy       (busy),
		.done       (done)
	);

endmodule

/* source/aes_wb_regs.sv */
`timescale 1ns/100ps

module aes_wb_regs import aes_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  wb_req_t    wb_in,
	output wb_rsp_t    wb_out,
	output aes_key_t   key,
	output aes_block_t plaintext,
	output logic       start,
	input  aes_block_t ciphertext,
	input  logic       busy,
	input  logic       done
);

	logic        ack_q;
	logic        start_q;
	logic        done_flag_q;
	logic [31:0] rd_q;
	aes_key_t    key_q;
	aes_block_t  text_q;

	logic        req;
	logic        take;
	logic        wr;
	logic        ctrl_start;
	logic [31:0] rd_data;

	assign req  = wb_in.cyc && wb_in.stb;
	// A request is taken once; the ack cycle blocks a second take.
	assign take = req && !ack_q;
	assign wr   = take && wb_in.we;

	assign ctrl_start = wr && (wb_in.adr == 4'd8) && wb_in.sel[0] && wb_in.dat[0];

	always_comb begin
		rd_data = 32'd0;
		case (wb_in.adr)
			4'd0, 4'd1, 4'd2, 4'd3: begin
				rd_data = key_q[wb_in.adr[1:0]];
			end
			4'd4, 4'd5, 4'd6, 4'd7: begin
				rd_data = text_q.w[wb_in.adr[1:0]];
			end
			4'd9: begin
				rd_data = {30'd0, done_flag_q, busy};
			end
			4'd12, 4'd13, 4'd14, 4'd15: begin
				rd_data = ciphertext.w[wb_in.adr[1:0]];
			end
			default: begin
				rd_data = 32'd0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q       <= 1'b0;
			start_q     <= 1'b0;
			done_flag_q <= 1'b0;
		end else begin
			ack_q   <= take;
			// Start while busy is dropped.
			start_q <= ctrl_start && !busy && !start_q;
			if (start_q) begin
				done_flag_q <= 1'b0;
			end else if (done) begin
				done_flag_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			rd_q <= rd_data;
		end
		// Key and plaintext stay frozen during a run.
		if (wr && !busy && !wb_in.adr[3]) begin
			for (int l = 0; l < 4; l++) begin
				if (wb_in.sel[l]) begin
					if (wb_in.adr[2]) begin
						text_q.w[wb_in.adr[1:0]][8*l +: 8] <= wb_in.dat[8*l +: 8];
					end else begin
						key_q[wb_in.adr[1:0]][8*l +: 8] <= wb_in.dat[8*l +: 8];
					end
				end
			end
		end
	end

	assign wb_out.ack = ack_q;
	assign wb_out.dat = rd_q;
	assign key        = key_q;
	assign plaintext  = text_q;
	assign start      = start_q;

	assert property (@(posedge clk) disable iff (reset)
		ack_q |-> $past(wb_in.cyc && wb_in.stb));

endmodule

/* tests/aes_tb.sv */
`timescale 1ns/100ps

module aes_tb import aes_pkg::*; ();

	localparam int num_kat = 3;
	// A known-answer run is about 55 cycles of bus traffic.
	localparam int cycle_limit = num_kat * 60 + 300;
	// Cycles from the ack of the start write to the done bit.
	localparam int start_to_done = 12;

	logic    clk;
	logic    reset;
	wb_req_t wb_in;
	wb_rsp_t wb_out;
	int      cycle_count = 0;

	string kat_name [0:num_kat-1] = '{"fips_c1", "fips_b", "all_zero"};

	aes_key_t kat_key [0:num_kat-1] = '{
		128'h000102030405060708090a0b0c0d0e0f,
		128'h2b7e151628aed2a6abf7158809cf4f3c,
		128'h00000000000000000000000000000000
	};

	aes_block_t kat_text [0:num_kat-1] = '{
		128'h00112233445566778899aabbccddeeff,
		128'h3243f6a8885a308d313198a2e0370734,
		128'h00000000000000000000000000000000
	};

	aes_block_t kat_ct [0:num_kat-1] = '{
		128'h69c4e0d86a7b0430d8cdb78070b4c55a,
		128'h3925841d02dc09fbdc118597196a0b32,
		128'h66e94bd4ef8a2c3b884cfa59ca342b2e
	};

	aes_top i_aes_top (
		.clk    (clk),
		.reset  (reset),
		.wb_in  (wb_in),
		.wb_out (wb_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic check_word(input string name, input logic [31:0] expected,
	                          input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error %s: expected %08h, actual %08h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "register value mismatch");
		end
	endtask

	task automatic check_block(input string name, input aes_block_t expected,
	                           input aes_block_t actual);
		if (actual !== expected) begin
			$display("error %s: expected %032h, actual %032h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "ciphertext mismatch");
		end
	endtask

	// Ack is sampled on the falling edge, away from the register updates.
	task automatic wait_ack();
		do begin
			@(negedge clk);
		end while (!wb_out.ack);
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat,
	                        input logic [3:0] sel);
		@(posedge clk);
		wb_in.cyc <= 1'b1;
		wb_in.stb <= 1'b1;
		wb_in.we  <= 1'b1;
		wb_in.adr <= adr;
		wb_in.dat <= dat;
		wb_in.sel <= sel;
		wait_ack();
		@(posedge clk);
		wb_in.cyc <= 1'b0;
		wb_in.stb <= 1'b0;
		wb_in.we  <= 1'b0;
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
		@(posedge clk);
		wb_in.cyc <= 1'b1;
		wb_in.stb <= 1'b1;
		wb_in.we  <= 1'b0;
		wb_in.adr <= adr;
		wb_in.sel <= 4'hf;
		wait_ack();
		dat = wb_out.dat;
		@(posedge clk);
		wb_in.cyc <= 1'b0;
		wb_in.stb <= 1'b0;
	endtask

	task automatic load_inputs(input aes_key_t key, input aes_block_t text);
		for (int i = 0; i < 4; i++) begin
			wb_write(4'(i), key[i], 4'hf);
		end
		for (int i = 0; i < 4; i++) begin
			wb_write(4'(4 + i), text.w[i], 4'hf);
		end
	endtask

	task automatic read_ciphertext(output aes_block_t ct);
		logic [31:0] word;
		for (int i = 0; i < 4; i++) begin
			wb_read(4'(12 + i), word);
			ct.w[i] = word;
		end
	endtask

	task automatic wait_done();
		logic [31:0] status;
		status = 32'd0;
		while (status[1] == 1'b0) begin
			wb_read(4'd9, status);
		end
	endtask

	task automatic run_kat(input int idx);
		aes_block_t  ct;
		logic [31:0] status;
		load_inputs(kat_key[idx], kat_text[idx]);
		wb_write(4'd8, 32'h00000001, 4'hf);
		wb_read(4'd9, status);
		check_word($sformatf("%s busy after start", kat_name[idx]), 32'h00000001, status);
		wait_done();
		read_ciphertext(ct);
		check_block(kat_name[idx], kat_ct[idx], ct);
	endtask

	task automatic check_registers();
		logic [31:0] words [0:7];
		logic [31:0] rd;
		for (int i = 0; i < 8; i++) begin
			words[i] = $urandom;
			wb_write(4'(i), words[i], 4'hf);
		end
		for (int i = 0; i < 8; i++) begin
			wb_read(4'(i), rd);
			check_word($sformatf("readback reg %0d", i), words[i], rd);
		end
		// Lanes 0 and 2 only.
		wb_write(4'd1, 32'h11223344, 4'hf);
		wb_write(4'd1, 32'haabbccdd, 4'b0101);
		wb_read(4'd1, rd);
		check_word("partial sel key", 32'h11bb33dd, rd);
		wb_write(4'd6, 32'h55667788, 4'hf);
		wb_write(4'd6, 32'h00000000, 4'b1000);
		wb_read(4'd6, rd);
		check_word("partial sel plaintext", 32'h00667788, rd);
		wb_read(4'd10, rd);
		check_word("unmapped reg 10", 32'h00000000, rd);
		wb_read(4'd11, rd);
		check_word("unmapped reg 11", 32'h00000000, rd);
	endtask

	task automatic check_back_pressure();
		aes_block_t  ct;
		logic [31:0] status;
		int          start_cycle;
		load_inputs(kat_key[0], kat_text[0]);
		wb_write(4'd8, 32'h00000001, 4'hf);
		start_cycle = cycle_count;
		wb_read(4'd9, status);
		check_word("back pressure busy", 32'h00000001, status);
		// Second start lands while the engine is running and is dropped.
		wb_write(4'd8, 32'h00000001, 4'hf);
		wait_done();
		// One status read adds up to four cycles to the done latency.
		if (cycle_count - start_cycle > start_to_done + 5) begin
			$display("back pressure: done came %0d cycles after the first start",
			         cycle_count - start_cycle);
			$display("TEST FAILED");
			$fatal(1, "the second start was not dropped");
		end
		for (int k = 0; k < 3; k++) begin
			wb_read(4'd9, status);
			check_word("back pressure done held", 32'h00000002, status);
		end
		read_ciphertext(ct);
		check_block("back pressure", kat_ct[0], ct);
	endtask

	initial begin
		logic [31:0] status;
		void'($urandom(47787));
		wb_in = '0;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		wb_read(4'd9, status);
		check_word("status after reset", 32'h00000000, status);
		for (int k = 0; k < num_kat; k++) begin
			run_kat(k);
		end
		check_registers();
		check_back_pressure();
		$display("TEST OK");
		$finish;
	end

endmodule
